// ==== obj_sys.f ====
obj_pkg.sv
obj_cfg_if.sv
obj_regs.sv
obj_table.sv
obj_scan.sv
obj_sys.sv
obj_checker.sv
tb_obj_sys.sv

// ==== Bender.yml ====
package:
  name: obj_sys

sources:
  - obj_pkg.sv
  - obj_cfg_if.sv
  - obj_regs.sv
  - obj_table.sv
  - obj_scan.sv
  - obj_sys.sv
  - target: test
    files:
      - obj_checker.sv
      - tb_obj_sys.sv

// ==== tb_obj_sys.sv ====
// ================================================
// testbench for the object list stage
// vram model answers every address
// vram_ok is random
// each image is chosen by the base register value
// ================================================
`timescale 1ns/1ps

module tb_obj_sys;

    logic                clk;
    logic                rst;
    logic                vb;
    logic                cpu_wr;
    logic [1:0]          cpu_addr;
    obj_pkg::vram_word_t cpu_wdata;
    obj_pkg::vram_word_t cpu_rdata;
    obj_pkg::vram_addr_t vram_addr;
    obj_pkg::vram_word_t vram_data;
    logic                vram_ok;
    logic                vram_cs;
    logic                scan_start;
    logic                obj_valid;
    obj_pkg::vram_word_t obj_x;
    obj_pkg::vram_word_t obj_y;
    obj_pkg::vram_word_t obj_code;
    obj_pkg::vram_word_t obj_attr;
    logic                scan_busy;
    logic                scan_done;
    obj_pkg::obj_count_t obj_count;
    integer              seed = 32'ha682_1dd7;
    logic [63:0]         ref_obj [0:255];  // reference list in scan order
    obj_pkg::vram_word_t rd;

    localparam obj_pkg::vram_word_t BASE_A = 16'h1238;  // list of 11
    localparam obj_pkg::vram_word_t BASE_B = 16'h2a50;  // list of 14
    localparam obj_pkg::vram_word_t BASE_C = 16'h0c18;  // list of 7

    obj_sys i_obj_sys (.*);
    obj_checker i_checker (.*);

    // image content with list length 4..19 from the region bits
    function automatic obj_pkg::vram_word_t vram_content(input obj_pkg::vram_addr_t a);
        logic [12:0] region;
        logic [7:0]  entry;
        region = a[23:11];
        entry  = a[10:3];
        if (a[2:1] != 2'd3) begin
            return a[16:1] ^ {region[7:0], 3'b010, region[12:8]};  // x, y, code
        end else if (entry == {4'h0, region[3:0]} + 8'd4) begin
            return {obj_pkg::END_MARK, entry};
        end
        return {4'h0, region[3:0], entry};  // attr high byte stays below ff
    endfunction

    // expected objects of one frame from image, base and limit
    function automatic int ref_list(input obj_pkg::vram_word_t base, input int limit);
        obj_pkg::vram_word_t attr;
        int                  n;
        n = 0;
        for (int e = 0; e < 256 && n < limit; e++) begin
            attr = vram_content({base[15:3], e[7:0], 2'd3});
            if (attr[15:8] == obj_pkg::END_MARK) begin
                break;
            end
            ref_obj[n] = {vram_content({base[15:3], e[7:0], 2'd0}),
                          vram_content({base[15:3], e[7:0], 2'd1}),
                          vram_content({base[15:3], e[7:0], 2'd2}), attr};
            n++;
        end
        return n;
    endfunction

    assign vram_data = vram_content(vram_addr);  // data with the address

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        vram_ok = 1'b0;
        forever begin
            @(posedge clk);
            #2 vram_ok = ($random(seed) & 3) != 0;  // ready 3 cycles in 4
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic cpu_write(input logic [1:0] a, input obj_pkg::vram_word_t d);
        next_cycle();
        cpu_wr    = 1'b1;
        cpu_addr  = a;
        cpu_wdata = d;
        next_cycle();
        cpu_wr = 1'b0;
    endtask

    task automatic read_check(input string what, input logic [1:0] a,
                              input obj_pkg::vram_word_t exp);
        next_cycle();
        cpu_addr = a;
        next_cycle();
        rd = cpu_rdata;  // registered read data
        i_checker.check_value(what, exp, rd);
    endtask

    task automatic end_blanking();
        next_cycle();
        vb = 1'b1;
        next_cycle();
        next_cycle();
        vb = 1'b0;  // falling edge ends blanking
    endtask

    task automatic wait_cs(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (vram_cs !== level && n < limit) begin
            next_cycle();
            n++;
        end
        if (vram_cs !== level) begin
            i_checker.report_error({"timeout waiting for ", what});
        end
    endtask

    task automatic copy_start(input obj_pkg::vram_word_t base);
        i_checker.begin_copy(base);
        cpu_write(obj_pkg::REG_BASE, base);
        end_blanking();
        wait_cs(1'b1, 10, "copy start");
    endtask

    task automatic copy_end();
        wait_cs(1'b0, 10000, "copy end");
        i_checker.check_value("copied words", 1024, i_checker.copy_words);
    endtask

    task automatic scan_expect(input obj_pkg::vram_word_t base, input int limit);
        int n;
        int t;
        n = ref_list(base, limit);
        for (int i = 0; i < n; i++) begin
            i_checker.add_obj(ref_obj[i]);
        end
        next_cycle();
        scan_start = 1'b1;
        next_cycle();
        scan_start = 1'b0;
        t = 0;
        while (!scan_done && t < 2000) begin
            next_cycle();
            t++;
        end
        if (!scan_done) begin
            i_checker.report_error("timeout waiting for scan_done");
        end
        next_cycle();  // checker sees the done pulse
    endtask

    initial begin
        rst        = 1'b1;
        vb         = 1'b0;
        cpu_wr     = 1'b0;
        cpu_addr   = 2'd0;
        cpu_wdata  = '0;
        scan_start = 1'b0;
        repeat (10) @(posedge clk);
        #2 rst = 1'b0;

        i_checker.begin_test("reset_regs");
        i_checker.check_value("vram_cs", 0, vram_cs);
        i_checker.check_value("scan_busy", 0, scan_busy);
        read_check("base", obj_pkg::REG_BASE, 16'd0);
        read_check("ctrl", obj_pkg::REG_CTRL, 16'd0);
        read_check("limit", obj_pkg::REG_LIMIT, 16'd256);
        read_check("stat", obj_pkg::REG_STAT, 16'd0);
        cpu_write(obj_pkg::REG_BASE, BASE_A);
        read_check("base", obj_pkg::REG_BASE, BASE_A);
        cpu_write(obj_pkg::REG_CTRL, 16'd1);
        read_check("ctrl", obj_pkg::REG_CTRL, 16'd1);
        cpu_write(obj_pkg::REG_LIMIT, 16'd300);  // clamped
        read_check("limit", obj_pkg::REG_LIMIT, 16'd256);
        cpu_write(obj_pkg::REG_LIMIT, 16'd77);
        read_check("limit", obj_pkg::REG_LIMIT, 16'd77);
        cpu_write(obj_pkg::REG_LIMIT, 16'd256);
        i_checker.end_test();

        i_checker.begin_test("copy_image");
        copy_start(BASE_A);
        read_check("stat", obj_pkg::REG_STAT, 16'd3);  // frame 1 and busy
        copy_end();
        read_check("stat", obj_pkg::REG_STAT, 16'd1);
        i_checker.end_test();

        i_checker.begin_test("double_buffer");
        copy_start(BASE_B);
        read_check("stat", obj_pkg::REG_STAT, 16'd2);  // frame back to 0
        scan_expect(BASE_A, 256);  // previous image now visible
        i_checker.check_value("copy running during scan", 1, vram_cs);
        copy_end();
        i_checker.end_test();

        i_checker.begin_test("end_marker");
        copy_start(BASE_C);
        scan_expect(BASE_B, 256);
        copy_end();
        i_checker.end_test();

        i_checker.begin_test("limit_no_copy");
        cpu_write(obj_pkg::REG_LIMIT, 16'd3);
        cpu_write(obj_pkg::REG_CTRL, 16'd0);
        end_blanking();
        for (int i = 0; i < 20; i++) begin
            next_cycle();
            if (vram_cs) begin
                i_checker.report_error("a copy started while copy_en was 0");
            end
        end
        read_check("stat", obj_pkg::REG_STAT, 16'd1);  // no flip and idle
        scan_expect(BASE_B, 3);
        i_checker.end_test();

        i_checker.print_totals();
        if (i_checker.errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== obj_checker.sv ====
// ================================================
// watches the DUT and compares its outputs with the
// expected object list and the copy address order
// expected list holds at most 256 entries
// ================================================
`timescale 1ns/1ps

module obj_checker (
    input logic                clk,
    input logic                rst,
    input obj_pkg::vram_addr_t vram_addr,
    input logic                vram_ok,
    input logic                vram_cs,
    input logic                obj_valid,
    input obj_pkg::vram_word_t obj_x,
    input obj_pkg::vram_word_t obj_y,
    input obj_pkg::vram_word_t obj_code,
    input obj_pkg::vram_word_t obj_attr,
    input logic                scan_done,
    input obj_pkg::obj_count_t obj_count
);

    string       test_name = "none";
    logic [63:0] exp_obj [0:255];     // x, y, code, attr packed
    int          exp_n = 0;
    int          got_n = 0;           // strobes seen this scan
    int          errors = 0;
    int          tests = 0;
    int          errs_at_start = 0;
    int          copy_words = 0;      // accepted vram words
    logic [12:0] copy_region = '0;    // base bits 15..3
    logic        copy_wait = 1'b0;    // one idle cycle after a taken word
    logic        take_now;

    task automatic begin_test(input string name);
        test_name     = name;
        exp_n         = 0;
        got_n         = 0;
        errs_at_start = errors;
    endtask

    task automatic add_obj(input logic [63:0] obj);
        exp_obj[exp_n] = obj;
        exp_n++;
    endtask

    task automatic begin_copy(input obj_pkg::vram_word_t base);
        copy_region = base[15:3];
        copy_words  = 0;
    endtask

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s %s: expected %0h actual %0h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        errors++;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s %s", test_name, (errors == errs_at_start) ? "ok" : "failed");
    endtask

    task automatic print_totals();
        $display("tests run %0d, errors %0d", tests, errors);
    endtask

    // sampled mid cycle, all DUT outputs settled
    always @(negedge clk) begin
        take_now = vram_cs && vram_ok && !copy_wait;
        if (rst) begin
            copy_wait = 1'b0;
        end else begin
            if (take_now) begin
                check_value("vram_addr", {copy_region, copy_words[9:0]}, vram_addr);
                copy_words++;
            end
            copy_wait = take_now;  // copier idles next cycle
        end
        if (obj_valid) begin
            if (got_n < exp_n) begin
                check_value($sformatf("object %0d", got_n), exp_obj[got_n],
                            {obj_x, obj_y, obj_code, obj_attr});
            end else begin
                report_error("object strobe beyond the end of the expected list");
            end
            got_n++;
        end
        if (scan_done) begin
            check_value("obj_count", exp_n, obj_count);
            check_value("strobes", exp_n, got_n);
        end
    end

endmodule

// ==== obj_sys.sv ====
// ================================================
// object list stage top level, plain ports only
// vram port has no arbitration, cs held for a copy
// ================================================
`timescale 1ns/1ps

module obj_sys (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 vb,
    input  logic                 cpu_wr,
    input  logic [1:0]           cpu_addr,
    input  obj_pkg::vram_word_t  cpu_wdata,
    output obj_pkg::vram_word_t  cpu_rdata,
    output obj_pkg::vram_addr_t  vram_addr,
    input  obj_pkg::vram_word_t  vram_data,
    input  logic                 vram_ok,
    output logic                 vram_cs,
    input  logic                 scan_start,
    output logic                 obj_valid,
    output obj_pkg::vram_word_t  obj_x,
    output obj_pkg::vram_word_t  obj_y,
    output obj_pkg::vram_word_t  obj_code,
    output obj_pkg::vram_word_t  obj_attr,
    output logic                 scan_busy,
    output logic                 scan_done,
    output obj_pkg::obj_count_t  obj_count
);

    obj_pkg::table_addr_t table_addr;  // scanner read address
    obj_pkg::vram_word_t  table_data;  // visible buffer data
    logic                 copy_busy;

    obj_cfg_if cfg ();

    obj_regs i_obj_regs (
        .clk       (clk),
        .rst       (rst),
        .cpu_wr    (cpu_wr),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .copy_busy (copy_busy),
        .cfg       (cfg.regs)
    );

    obj_table i_obj_table (
        .clk        (clk),
        .rst        (rst),
        .vb         (vb),
        .vram_addr  (vram_addr),
        .vram_data  (vram_data),
        .vram_ok    (vram_ok),
        .vram_cs    (vram_cs),
        .copy_busy  (copy_busy),
        .table_addr (table_addr),
        .table_data (table_data),
        .cfg        (cfg.tbl)
    );

    obj_scan i_obj_scan (
        .clk        (clk),
        .rst        (rst),
        .scan_start (scan_start),
        .table_addr (table_addr),
        .table_data (table_data),
        .obj_valid  (obj_valid),
        .obj_x      (obj_x),
        .obj_y      (obj_y),
        .obj_code   (obj_code),
        .obj_attr   (obj_attr),
        .scan_busy  (scan_busy),
        .scan_done  (scan_done),
        .obj_count  (obj_count),
        .cfg        (cfg.scan)
    );

endmodule

// ==== obj_scan.sv ====
// ================================================
// walks the visible table, 5 cycles per entry
// stops on attr high byte ff or at obj_limit
// scan_start is ignored while scan_busy is high
// field outputs are valid only with obj_valid
// ================================================
`timescale 1ns/1ps

module obj_scan (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 scan_start,
    output obj_pkg::table_addr_t table_addr,
    input  obj_pkg::vram_word_t  table_data,
    output logic                 obj_valid,
    output obj_pkg::vram_word_t  obj_x,
    output obj_pkg::vram_word_t  obj_y,
    output obj_pkg::vram_word_t  obj_code,
    output obj_pkg::vram_word_t  obj_attr,
    output logic                 scan_busy,
    output logic                 scan_done,
    output obj_pkg::obj_count_t  obj_count,
    obj_cfg_if.scan              cfg
);

    obj_pkg::scan_state_t st;
    logic [7:0]           entry;    // entry being read
    logic [2:0]           phase;    // read issue 0..3, collect 1..4
    obj_pkg::obj_count_t  count;
    logic                 last_wd;  // attr word arrives this cycle

    assign table_addr = {entry, phase[1:0]};
    assign last_wd    = (phase == 3'(obj_pkg::OBJ_WORDS));
    assign scan_busy  = (st != obj_pkg::SCAN_IDLE);
    assign scan_done  = (st == obj_pkg::SCAN_DONE);
    assign obj_count  = count;

    // collect words one cycle after their address
    always_ff @(posedge clk) begin
        case (phase)
            3'd1:    obj_x    <= table_data;
            3'd2:    obj_y    <= table_data;
            3'd3:    obj_code <= table_data;
            3'd4:    obj_attr <= table_data;
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= obj_pkg::SCAN_IDLE;
            entry     <= '0;
            phase     <= '0;
            count     <= '0;
            obj_valid <= 1'b0;
        end else begin
            obj_valid <= 1'b0;
            case (st)
                obj_pkg::SCAN_IDLE: begin
                    entry <= '0;
                    phase <= '0;
                    if (scan_start) begin
                        count <= '0;
                        st    <= (cfg.obj_limit == '0) ? obj_pkg::SCAN_DONE
                                                       : obj_pkg::SCAN_READ;
                    end
                end
                obj_pkg::SCAN_READ: begin
                    phase <= phase + 3'd1;
                    if (last_wd) begin
                        phase <= '0;
                        if (table_data[15:8] == obj_pkg::END_MARK) begin
                            st <= obj_pkg::SCAN_DONE;  // end of list
                        end else begin
                            obj_valid <= 1'b1;
                            count     <= count + 9'd1;
                            entry     <= entry + 8'd1;
                            if (count + 9'd1 == cfg.obj_limit) begin
                                st <= obj_pkg::SCAN_DONE;  // limit hit
                            end
                        end
                    end
                end
                obj_pkg::SCAN_DONE: st <= obj_pkg::SCAN_IDLE;  // done pulse
                default:            st <= obj_pkg::SCAN_IDLE;
            endcase
        end
    end

endmodule

// ==== obj_table.sv ====
// ================================================
// copies the 1024-word object table from vram into
// the hidden half of a 2048-word double buffer
// frame flips when a copy starts at end of blanking
// vram_ok low stalls the copy, no timeout
// ================================================
`timescale 1ns/1ps

module obj_table (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 vb,
    output obj_pkg::vram_addr_t  vram_addr,
    input  obj_pkg::vram_word_t  vram_data,
    input  logic                 vram_ok,
    output logic                 vram_cs,
    output logic                 copy_busy,
    input  obj_pkg::table_addr_t table_addr,
    output obj_pkg::vram_word_t  table_data,
    obj_cfg_if.tbl               cfg
);

    obj_pkg::copy_state_t st;
    obj_pkg::table_addr_t wr_idx;      // next word to write
    logic                 last_vb;     // vb one cycle late
    logic                 wait_cycle;  // idle cycle after each word
    logic                 vb_end;
    logic                 take;

    // two buffers, frame selects the visible one
    obj_pkg::vram_word_t table_ram [0:2047];

    assign vb_end    = last_vb && !vb;  // blanking just ended
    assign take      = (st == obj_pkg::COPY_RUN) && vram_ok && !wait_cycle;
    assign vram_cs   = (st == obj_pkg::COPY_RUN);
    assign copy_busy = (st == obj_pkg::COPY_RUN);

    // copy goes to the half the scanner does not see
    always_ff @(posedge clk) begin
        if (take) begin
            table_ram[{~cfg.frame, wr_idx}] <= vram_data;
        end
    end

    // renderer read port, data one cycle after address
    always_ff @(posedge clk) begin
        table_data <= table_ram[{cfg.frame, table_addr}];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= obj_pkg::COPY_IDLE;
            cfg.frame  <= 1'b0;
            last_vb    <= 1'b0;
            wait_cycle <= 1'b0;
            wr_idx     <= '0;
            vram_addr  <= '0;
        end else begin
            last_vb <= vb;
            case (st)
                obj_pkg::COPY_IDLE: begin
                    // keep start address ready from base reg
                    vram_addr  <= {cfg.vram_base[15:3], 10'd0};
                    wr_idx     <= '0;
                    wait_cycle <= 1'b0;
                    if (vb_end && cfg.copy_en) begin
                        cfg.frame <= ~cfg.frame;  // last copy becomes visible
                        st        <= obj_pkg::COPY_RUN;
                    end
                end
                obj_pkg::COPY_RUN: begin
                    wait_cycle <= take;  // one wait after every word
                    if (take) begin
                        vram_addr[10:1] <= vram_addr[10:1] + 10'd1;
                        wr_idx          <= wr_idx + 10'd1;
                        if (wr_idx == obj_pkg::TABLE_LAST) begin
                            st <= obj_pkg::COPY_IDLE;  // word 1023 taken
                        end
                    end
                end
                default: st <= obj_pkg::COPY_IDLE;
            endcase
        end
    end

endmodule

// ==== obj_regs.sv ====
// ================================================
// cpu register block, write on any cpu_wr cycle
// read data is registered, one cycle after address
// limit writes above 256 are clamped to 256
// ================================================
`timescale 1ns/1ps

module obj_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_wr,
    input  logic [1:0]          cpu_addr,
    input  obj_pkg::vram_word_t cpu_wdata,
    output obj_pkg::vram_word_t cpu_rdata,
    input  logic                copy_busy,
    obj_cfg_if.regs             cfg
);

    obj_pkg::obj_count_t limit_wr;  // clamped write value

    // only 256 entries fit in the table
    always_comb begin
        if (cpu_wdata > 16'(obj_pkg::OBJ_MAX)) begin
            limit_wr = obj_pkg::OBJ_MAX;
        end else begin
            limit_wr = cpu_wdata[8:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg.vram_base <= '0;
            cfg.copy_en   <= 1'b0;
            cfg.obj_limit <= obj_pkg::OBJ_MAX;  // no limit by default
        end else if (cpu_wr) begin
            case (cpu_addr)
                obj_pkg::REG_BASE:  cfg.vram_base <= cpu_wdata;
                obj_pkg::REG_CTRL:  cfg.copy_en   <= cpu_wdata[0];
                obj_pkg::REG_LIMIT: cfg.obj_limit <= limit_wr;
                default: ;  // status is read only
            endcase
        end
    end

    // read mux, registered
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_rdata <= '0;
        end else begin
            case (cpu_addr)
                obj_pkg::REG_BASE:  cpu_rdata <= cfg.vram_base;
                obj_pkg::REG_CTRL:  cpu_rdata <= {15'd0, cfg.copy_en};
                obj_pkg::REG_LIMIT: cpu_rdata <= {7'd0, cfg.obj_limit};
                default:            cpu_rdata <= {14'd0, copy_busy, cfg.frame};
            endcase
        end
    end

endmodule

// ==== obj_cfg_if.sv ====
// ================================================
// configuration and frame status between the
// register block, the table copier and the scanner
// the copier connects through modport tbl
// ================================================
`timescale 1ns/1ps

interface obj_cfg_if;

    obj_pkg::vram_word_t vram_base;  // table location in vram
    logic                copy_en;    // copy on end of blanking
    obj_pkg::obj_count_t obj_limit;  // max objects per scan
    logic                frame;      // buffer the scanner reads

    modport regs (
        output vram_base,
        output copy_en,
        output obj_limit,
        input  frame
    );

    modport tbl (
        input  vram_base,
        input  copy_en,
        output frame
    );

    modport scan (
        input  obj_limit
    );

endinterface

// ==== obj_pkg.sv ====
// ================================================
// shared types and constants of the object stage
// object entry is 4 words: x, y, code, attribute
// table is 1024 words, so 256 entries at most
// ================================================
package obj_pkg;

    typedef logic [15:0] vram_word_t;   // one vram or table word
    typedef logic [23:1] vram_addr_t;   // vram word address
    typedef logic [9:0]  table_addr_t;  // word index in one buffer
    typedef logic [8:0]  obj_count_t;   // 0 to 256 objects

    localparam int          OBJ_WORDS  = 4;        // x, y, code, attr
    localparam logic [7:0]  END_MARK   = 8'hff;    // attr high byte ends list
    localparam obj_count_t  OBJ_MAX    = 9'd256;   // full table of entries
    localparam table_addr_t TABLE_LAST = 10'h3ff;  // last word of a copy

    // cpu register indices
    localparam logic [1:0] REG_BASE  = 2'd0;
    localparam logic [1:0] REG_CTRL  = 2'd1;
    localparam logic [1:0] REG_LIMIT = 2'd2;
    localparam logic [1:0] REG_STAT  = 2'd3;

    typedef enum logic {
        COPY_IDLE,  // waiting for end of blanking
        COPY_RUN    // reading 1024 words from vram
    } copy_state_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_READ,  // walking entries
        SCAN_DONE   // one cycle, count is final
    } scan_state_t;

endpackage
